//--- dv/fpAdderTb.sv
// Floating-point adder testbench
`timescale 1ns/1ns
`default_nettype none

module fpAdderTb;

    // Final vectors go in back-to-back
    localparam int burstLength = 8;

    logic            clk;
    logic            arstN;
    logic            inValid;
    fpAddPkg::fpWord a;
    fpAddPkg::fpWord b;
    logic            outValid;
    fpAddPkg::fpWord sum;

    logic [31:0] vecA[$];
    logic [31:0] vecB[$];
    logic [31:0] vecSum[$];

    // Results in flight, oldest first
    logic [31:0] expectQ[$];
    int          issueCycleQ[$];

    int cycleCount = 0;
    int cycleLimit = 0;
    int checkCount = 0;
    int valueErrors = 0;
    int protocolErrors = 0;

    fpAdder dut0
    (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .a        (a),
        .b        (b),
        .outValid (outValid),
        .sum      (sum)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected)
        begin
            valueErrors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Three hex words per line, anything else is skipped
    task automatic readVectors(output bit ok);
        int          fd;
        int          fields;
        string       line;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] vs;
        fd = $fopen("dv/fpAdderTestdata.txt", "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0)
            begin
                fields = $sscanf(line, "%h %h %h", va, vb, vs);
                if (fields == 3)
                begin
                    vecA.push_back(va);
                    vecB.push_back(vb);
                    vecSum.push_back(vs);
                end
            end
            $fclose(fd);
        end
        ok = (vecA.size() > 0);
    endtask

    always @(posedge clk)
    begin
        cycleCount++;
        if ((cycleLimit > 0) && (cycleCount >= cycleLimit))
        begin
            $display("Run timed out after %0d cycles with %0d results still pending",
                     cycleCount, expectQ.size());
            $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                     checkCount, valueErrors, protocolErrors);
            $display("Some tests failed");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle
    always @(negedge clk)
    begin
        if (arstN && outValid)
        begin
            if (expectQ.size() == 0)
            begin
                protocolErrors++;
                $display("Result strobe at %0t with no input waiting for it", $time);
            end
            else
            begin
                checkValue(sum.raw, expectQ.pop_front(), "sum");
                checkValue(32'(cycleCount - issueCycleQ.pop_front()), 32'd3, "latency");
            end
        end
    end

    initial
    begin
        bit ok;
        int gap;
        int issueCycle;

        clk     = 1'b0;
        arstN   = 1'b0;
        inValid = 1'b0;
        a       = '0;
        b       = '0;

        void'($urandom(32'he851abc7));
        readVectors(ok);
        if (!ok)
        begin
            protocolErrors++;
            $display("Could not read any vectors from dv/fpAdderTestdata.txt");
        end
        cycleLimit = 3 * vecA.size() + 50;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // A few idle cycles where outValid must stay low
        repeat (2) @(negedge clk);

        for (int i = 0; i < vecA.size(); i++)
        begin
            a.raw      = vecA[i];
            b.raw      = vecB[i];
            inValid    = 1'b1;
            issueCycle = cycleCount;
            @(posedge clk);
            expectQ.push_back(vecSum[i]);
            issueCycleQ.push_back(issueCycle);
            @(negedge clk);
            inValid = 1'b0;
            gap     = (i < vecA.size() - burstLength) ? int'($urandom % 3) : 0;
            repeat (gap) @(negedge clk);
        end

        while (expectQ.size() != 0)
            @(negedge clk);

        // Catch any stray strobe after the last result
        repeat (4) @(negedge clk);

        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checkCount, valueErrors, protocolErrors);
        if ((valueErrors == 0) && (protocolErrors == 0))
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/fpAdderTestdata.txt
# Columns: operand A, operand B, expected sum, each a 32-bit hex word
# Lines starting with # are skipped
# Equal signs, carry out, wide exponent gap
3F800000 3F800000 40000000
3FC00000 3FC00000 40400000
40200000 3F400000 40500000
42C80000 3F000000 42C90000
BF800000 C0000000 C0400000
4B000000 3F800000 4B000001
3F800000 30800000 3F800000
# Opposite signs and cancellation
3F800000 BF800000 00000000
BF800000 3F800000 00000000
3F800001 BF800000 34000000
3F800000 BF7FFFFF 33800000
3F800000 BFC00000 BF000000
3FC00000 BFA00000 3E800000
3F800000 B3000000 3F800000
# Round to nearest-even
3F800000 33800000 3F800000
3F800001 33800000 3F800002
3F800000 33820000 3F800001
3FFFFFFF 33800000 40000000
4B7FFFFF 3F800000 4B800000
4B800000 40400000 4B800002
# Special operands
7FC00000 3F800000 7FC00000
3F800000 7F800001 7FC00000
FFC12345 7F800000 7FC00000
7F800000 3F800000 7F800000
C2C80000 FF800000 FF800000
7F800000 FF800000 7FC00000
00400000 3F800000 3F800000
80000000 80000000 80000000
00000001 80000005 00000000
# Overflow and flush to zero
7F7FFFFF 7F7FFFFF 7F800000
FF7FFFFF FF7FFFFF FF800000
7F7FFFFF 73000000 7F800000
00800001 80800000 00000000
80800001 00800000 80000000
01000000 80800000 00800000

//--- files.f
verilog/fpAddPkg.sv
verilog/fpUnpackAlign.sv
verilog/fpMantissaAdd.sv
verilog/fpNormalize.sv
verilog/fpAdder.sv
dv/fpAdderTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the adder testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f files.f --top-module fpAdderTb -o fpAdderSim

./obj_dir/fpAdderSim | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verilog/fpAddPkg.sv
// Floating-point adder definitions
`default_nettype none

package fpAddPkg;

    // Single-precision field widths
    localparam int expWidth = 8;
    localparam int manWidth = 23;

    localparam logic [expWidth-1:0] expMax = 8'd255;
    localparam int bias = 127;

    // Canonical quiet NaN
    localparam logic [31:0] quietNan = 32'h7FC0_0000;

    typedef struct packed {
        logic                sign;
        logic [expWidth-1:0] exponent;
        logic [manWidth-1:0] mantissa;
    } fpFields;

    // Same word seen raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        fpFields     fields;
    } fpWord;

    typedef enum logic [1:0] {
        none = 2'd0,
        nan  = 2'd1,
        inf  = 2'd2,
        zero = 2'd3
    } fpSpecial;

    // Stage one output, larger magnitude first
    typedef struct packed {
        logic                bigSign;
        logic                smallSign;
        logic [manWidth:0]   bigMan;
        logic [manWidth:0]   smallMan;
        logic                guardBit;
        logic                roundBit;
        logic                stickyBit;
        logic [expWidth-1:0] exponent;
        fpSpecial            specialCase;
        logic                specialSign;
    } alignedOp;

    // Stage two output, raw sum before normalization
    typedef struct packed {
        logic                sign;
        logic [manWidth:0]   sumMan;
        logic                carryOut;
        logic                guardBit;
        logic                roundBit;
        logic                stickyBit;
        logic [expWidth-1:0] exponent;
        fpSpecial            specialCase;
        logic                specialSign;
    } sumOp;

endpackage

`default_nettype wire

//--- verilog/fpAdder.sv
// Pipelined single-precision adder
`timescale 1ns/1ns
`default_nettype none

module fpAdder
(
    input  logic            clk,
    input  logic            arstN,
    input  logic            inValid,
    input  fpAddPkg::fpWord a,
    input  fpAddPkg::fpWord b,
    output logic            outValid,
    output fpAddPkg::fpWord sum
);

    logic               alignValid;
    fpAddPkg::alignedOp aligned;
    logic               sumValid;
    fpAddPkg::sumOp     addResult;

    // Classify, order and align
    fpUnpackAlign unpack0
    (
        .clk        (clk),
        .arstN      (arstN),
        .inValid    (inValid),
        .a          (a),
        .b          (b),
        .alignValid (alignValid),
        .aligned    (aligned)
    );

    fpMantissaAdd add0
    (
        .clk        (clk),
        .arstN      (arstN),
        .alignValid (alignValid),
        .aligned    (aligned),
        .sumValid   (sumValid),
        .sum        (addResult)
    );

    // Normalize, round, resolve specials
    fpNormalize norm0
    (
        .clk      (clk),
        .arstN    (arstN),
        .sumValid (sumValid),
        .sum      (addResult),
        .outValid (outValid),
        .result   (sum)
    );

endmodule

`default_nettype wire

//--- verilog/fpMantissaAdd.sv
// Mantissa add and subtract stage
`timescale 1ns/1ns
`default_nettype none

module fpMantissaAdd
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               alignValid,
    input  fpAddPkg::alignedOp aligned,
    output logic               sumValid,
    output fpAddPkg::sumOp     sum
);

    logic [fpAddPkg::manWidth+1:0] total;
    logic [fpAddPkg::manWidth+3:0] bigExt;
    logic [fpAddPkg::manWidth+3:0] smallExt;
    logic [fpAddPkg::manWidth+4:0] diff;
    fpAddPkg::sumOp                sumNext;

    always_comb
    begin
        total    = {1'b0, aligned.bigMan} + {1'b0, aligned.smallMan};

        // Borrow runs through the tail bits too
        bigExt   = {aligned.bigMan, 3'b000};
        smallExt = {aligned.smallMan, aligned.guardBit, aligned.roundBit, aligned.stickyBit};
        diff     = {1'b0, bigExt} - {1'b0, smallExt};

        sumNext.exponent    = aligned.exponent;
        sumNext.specialCase = aligned.specialCase;
        sumNext.specialSign = aligned.specialSign;

        if (aligned.bigSign == aligned.smallSign)
        begin
            sumNext.sign      = aligned.bigSign;
            sumNext.sumMan    = total[fpAddPkg::manWidth:0];
            sumNext.carryOut  = total[fpAddPkg::manWidth+1];
            sumNext.guardBit  = aligned.guardBit;
            sumNext.roundBit  = aligned.roundBit;
            sumNext.stickyBit = aligned.stickyBit;
        end
        else
        begin
            // x + (-x) is +0
            sumNext.sign      = (diff == '0) ? 1'b0 : aligned.bigSign;
            sumNext.sumMan    = diff[fpAddPkg::manWidth+3:3];
            // Only a borrow out of the top, which the ordering rules out
            sumNext.carryOut  = diff[fpAddPkg::manWidth+4];
            sumNext.guardBit  = diff[2];
            sumNext.roundBit  = diff[1];
            sumNext.stickyBit = diff[0];
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            sumValid <= 1'b0;
            sum      <= '0;
        end
        else
        begin
            sumValid <= alignValid;
            if (alignValid)
                sum <= sumNext;
        end
    end

    // Effective subtraction can never carry out
    noCarryOnSubtract: assert property (@(posedge clk) disable iff (!arstN)
        alignValid && (aligned.bigSign != aligned.smallSign) |=> !sum.carryOut);

endmodule

`default_nettype wire

//--- verilog/fpNormalize.sv
// Normalize, round and special-case stage
`timescale 1ns/1ns
`default_nettype none

module fpNormalize
(
    input  logic            clk,
    input  logic            arstN,
    input  logic            sumValid,
    input  fpAddPkg::sumOp  sum,
    output logic            outValid,
    output fpAddPkg::fpWord result
);

    // Leading zeros of mantissa plus tail, 27 when all clear
    function automatic logic [4:0] countZeros(input logic [fpAddPkg::manWidth+3:0] value);
        logic [4:0] count;
        count = 5'd27;
        for (int i = 0; i <= fpAddPkg::manWidth + 3; i++)
            if (value[i])
                count = 5'(fpAddPkg::manWidth + 3 - i);
        return count;
    endfunction

    logic [fpAddPkg::manWidth+3:0] fullMan;
    logic [4:0]                    zeroCount;
    logic [fpAddPkg::manWidth+3:0] shifted;
    logic [fpAddPkg::manWidth:0]   normMan;
    logic                          guardBit;
    logic                          restBits;
    logic                          roundUp;
    logic [fpAddPkg::manWidth+1:0] rounded;
    logic [fpAddPkg::manWidth-1:0] finalMan;
    int                            expNorm;
    int                            expRounded;
    int                            trueExpNorm;
    int                            trueExpRounded;
    fpAddPkg::fpWord               resultNext;

    always_comb
    begin
        fullMan   = {sum.sumMan, sum.guardBit, sum.roundBit, sum.stickyBit};
        zeroCount = countZeros(fullMan);
        shifted   = fullMan << zeroCount;

        if (sum.carryOut)
        begin
            // One place right, dropped bit joins the tail
            normMan  = {1'b1, sum.sumMan[fpAddPkg::manWidth:1]};
            guardBit = sum.sumMan[0];
            restBits = sum.guardBit | sum.roundBit | sum.stickyBit;
            expNorm  = int'(sum.exponent) + 1;
        end
        else
        begin
            normMan  = shifted[fpAddPkg::manWidth+3:3];
            guardBit = shifted[2];
            restBits = |shifted[1:0];
            expNorm  = int'(sum.exponent) - int'(zeroCount);
        end

        // Nearest-even
        roundUp = guardBit & (restBits | normMan[0]);
        rounded = {1'b0, normMan} + {{(fpAddPkg::manWidth + 1){1'b0}}, roundUp};

        // Rounding carry means mantissa wrapped to 1.0
        if (rounded[fpAddPkg::manWidth+1])
        begin
            finalMan   = rounded[fpAddPkg::manWidth:1];
            expRounded = expNorm + 1;
        end
        else
        begin
            finalMan   = rounded[fpAddPkg::manWidth-1:0];
            expRounded = expNorm;
        end

        trueExpNorm    = expNorm - fpAddPkg::bias;
        trueExpRounded = expRounded - fpAddPkg::bias;

        if (sum.specialCase == fpAddPkg::nan)
            resultNext.raw = fpAddPkg::quietNan;
        else if (sum.specialCase == fpAddPkg::inf)
            resultNext.raw = {sum.specialSign, fpAddPkg::expMax, {fpAddPkg::manWidth{1'b0}}};
        else if (sum.specialCase == fpAddPkg::zero)
            resultNext.raw = {sum.specialSign, 31'b0};
        else if ((fullMan == '0) && !sum.carryOut)
            resultNext.raw = {sum.sign, 31'b0};
        // Below the smallest normal, flush to signed zero
        else if (trueExpNorm < 1 - fpAddPkg::bias)
            resultNext.raw = {sum.sign, 31'b0};
        else if (trueExpRounded > fpAddPkg::bias)
            resultNext.raw = {sum.sign, fpAddPkg::expMax, {fpAddPkg::manWidth{1'b0}}};
        else
            resultNext.raw = {sum.sign, 8'(expRounded), finalMan};
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= sumValid;
            if (sumValid)
                result <= resultNext;
        end
    end

    // Every result strobe is backed by a sum strobe one cycle earlier
    outFollowsSum: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> $past(sumValid));

endmodule

`default_nettype wire

//--- verilog/fpUnpackAlign.sv
// Operand unpack and alignment stage
`timescale 1ns/1ns
`default_nettype none

module fpUnpackAlign
(
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  fpAddPkg::fpWord    a,
    input  fpAddPkg::fpWord    b,
    output logic               alignValid,
    output fpAddPkg::alignedOp aligned
);

    logic aNan;
    logic aInf;
    logic aZero;
    logic bNan;
    logic bInf;
    logic bZero;

    // Effective fields, subnormals read as zero
    logic [fpAddPkg::expWidth-1:0] aExp;
    logic [fpAddPkg::expWidth-1:0] bExp;
    logic [fpAddPkg::manWidth:0]   aMan;
    logic [fpAddPkg::manWidth:0]   bMan;

    logic                          aIsBig;
    logic [fpAddPkg::expWidth-1:0] bigExp;
    logic [fpAddPkg::expWidth-1:0] smallExp;
    logic [fpAddPkg::expWidth-1:0] expDiff;
    logic [fpAddPkg::manWidth:0]   bigMan;
    logic [fpAddPkg::manWidth:0]   smallMan;
    logic [4:0]                    shiftAmt;
    logic [fpAddPkg::manWidth+26:0] shiftedSmall;

    fpAddPkg::fpSpecial special;
    logic               specialSign;
    fpAddPkg::alignedOp alignNext;

    always_comb
    begin
        // Classify both operands
        aNan  = (a.fields.exponent == fpAddPkg::expMax) && (a.fields.mantissa != '0);
        aInf  = (a.fields.exponent == fpAddPkg::expMax) && (a.fields.mantissa == '0);
        aZero = (a.fields.exponent == '0);
        bNan  = (b.fields.exponent == fpAddPkg::expMax) && (b.fields.mantissa != '0);
        bInf  = (b.fields.exponent == fpAddPkg::expMax) && (b.fields.mantissa == '0);
        bZero = (b.fields.exponent == '0);

        // A zero class already has a zero exponent
        aExp = a.fields.exponent;
        bExp = b.fields.exponent;
        aMan = aZero ? '0 : {1'b1, a.fields.mantissa};
        bMan = bZero ? '0 : {1'b1, b.fields.mantissa};

        // Order by magnitude
        aIsBig   = {aExp, aMan} >= {bExp, bMan};
        bigExp   = aIsBig ? aExp : bExp;
        smallExp = aIsBig ? bExp : aExp;
        bigMan   = aIsBig ? aMan : bMan;
        smallMan = aIsBig ? bMan : aMan;

        // Beyond 26 places only sticky survives
        expDiff      = bigExp - smallExp;
        shiftAmt     = (expDiff >= 8'd26) ? 5'd26 : expDiff[4:0];
        shiftedSmall = {smallMan, 26'b0} >> shiftAmt;

        special     = fpAddPkg::none;
        specialSign = 1'b0;
        if (aNan || bNan || (aInf && bInf && (a.fields.sign != b.fields.sign)))
            special = fpAddPkg::nan;
        else if (aInf || bInf)
        begin
            special     = fpAddPkg::inf;
            specialSign = aInf ? a.fields.sign : b.fields.sign;
        end
        else if (aZero && bZero)
        begin
            special     = fpAddPkg::zero;
            specialSign = a.fields.sign & b.fields.sign;
        end

        alignNext.bigSign     = aIsBig ? a.fields.sign : b.fields.sign;
        alignNext.smallSign   = aIsBig ? b.fields.sign : a.fields.sign;
        alignNext.bigMan      = bigMan;
        alignNext.smallMan    = shiftedSmall[fpAddPkg::manWidth+26:26];
        alignNext.guardBit    = shiftedSmall[25];
        alignNext.roundBit    = shiftedSmall[24];
        alignNext.stickyBit   = |shiftedSmall[23:0];
        alignNext.exponent    = bigExp;
        alignNext.specialCase = special;
        alignNext.specialSign = specialSign;
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            alignValid <= 1'b0;
            aligned    <= '0;
        end
        else
        begin
            alignValid <= inValid;
            if (inValid)
                aligned <= alignNext;
        end
    end

    // A finite, non-zero pair always leads with a normalized mantissa
    bigManNormalized: assert property (@(posedge clk) disable iff (!arstN)
        alignValid && (aligned.specialCase == fpAddPkg::none)
            |-> aligned.bigMan[fpAddPkg::manWidth]);

endmodule

`default_nettype wire
